//--- hazardTop.f
+incdir+include
logic/mipsPkg.sv
logic/instrDecode.sv
logic/stageTracker.sv
logic/hazard.sv
logic/hazardTop.sv
tb/hazardTb.sv

//--- runSim.sh
#!/bin/sh
# build the hazard unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f hazardTop.f --top-module hazardTb -o hazardSim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/hazardSim)
echo "$out"

echo "$out" | grep -qx "TEST PASSED" && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }

//--- tb/hazardTb.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module hazardTb import mipsPkg::*; ();
    localparam int cycleLimit = 400;

    logic                    clk;
    logic                    rstN;
    logic [`MIPS_WORD_W-1:0] instrD;
    logic                    iDataOk;
    logic                    dDataOk;
    logic                    exceptionValid;
    logic                    isEret;
    logic                    stallF, stallD, stallE, stallM;
    logic                    flushD, flushE, flushM, flushW, flushEx;
    forwardT                 forwardAD, forwardBD, forwardAE, forwardBE;

    // shadow words held in E, M and W
    logic [`MIPS_WORD_W-1:0] wE, wM, wW;
    logic                    expStallFD, expStallEM, expFlushE, expFlushW, expFlushEx;
    integer                  seed;
    int                      cycles = 0;

    hazardTop dut_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycleLimit) begin
            abortRun("timeout: the run went past its cycle limit without finishing");
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt);
        return {op, rs, rt, 16'h0004};
    endfunction

    function automatic logic [31:0] cop0(input logic [4:0] code, input logic [4:0] rt,
                                         input logic [4:0] rd);
        return {`MIPS_OP_COP0, code, rt, rd, 11'd0};
    endfunction

    // destination register of a word or zero when it writes none
    function automatic logic [4:0] destOf(input logic [31:0] w);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] d;
        op = w[31:26];
        fn = w[5:0];
        d = 5'd0;
        if (op == `MIPS_OP_SPECIAL && fn inside {`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND,
                                                 `MIPS_FN_OR, `MIPS_FN_MFHI, `MIPS_FN_MFLO}) begin
            d = w[15:11];
        end else if (op == `MIPS_OP_LW || op == `MIPS_OP_ADDIU) begin
            d = w[20:16];
        end else if (op == `MIPS_OP_COP0 && w[25:21] == `MIPS_CP0_MF) begin
            d = w[20:16];
        end
        return d;
    endfunction

    function automatic logic passesA(input logic [31:0] w);
        return (w[31:26] == `MIPS_OP_SPECIAL &&
                (w[5:0] == `MIPS_FN_MFHI || w[5:0] == `MIPS_FN_MFLO)) ||
               (w[31:26] == `MIPS_OP_COP0 && w[25:21] == `MIPS_CP0_MF);
    endfunction

    function automatic forwardT fwdD(input logic [4:0] src);
        if (src == 5'd0) return NOFORWARD;
        if (destOf(wE) == src && passesA(wE)) return ALUSRCAE;
        if (destOf(wM) == src) return ALUOUTM;
        if (destOf(wW) == src) return RESULTW;
        return NOFORWARD;
    endfunction

    // plain register operands only
    function automatic forwardT fwdE(input logic [4:0] src);
        if (src == 5'd0) return NOFORWARD;
        if (destOf(wM) == src) return ALUOUTM;
        if (destOf(wW) == src) return RESULTW;
        return NOFORWARD;
    endfunction

    task automatic checkShadowFwd();
        #1;
        checkEq(32'(forwardAD), 32'(fwdD(instrD[25:21])), "forwardAD");
        checkEq(32'(forwardBD), 32'(fwdD(instrD[20:16])), "forwardBD");
        checkEq(32'(forwardAE), 32'(fwdE(wE[25:21])), "forwardAE");
        checkEq(32'(forwardBE), 32'(fwdE(wE[20:16])), "forwardBE");
    endtask

    // check stalls and flushes before stepping the shadow stages over one edge
    task automatic advance();
        #1;
        checkEq(32'({stallF, stallD, stallE, stallM}),
                32'({expStallFD, expStallFD, expStallEM, expStallEM}), "stall F/D/E/M");
        checkEq(32'({flushD, flushE, flushM, flushW, flushEx}),
                32'({expFlushEx, expFlushE, expFlushEx, expFlushW, expFlushEx}),
                "flush D/E/M/W/Ex");
        @(posedge clk);
        wW = expFlushW ? '0 : wM;
        if (!expStallEM) begin
            wM = expFlushEx ? '0 : wE;
            wE = expFlushE ? '0 : instrD;
        end
        #2;
        {expStallFD, expStallEM, expFlushE, expFlushW, expFlushEx} = '0;
    endtask

    task automatic drain();
        repeat (3) begin
            instrD = '0;
            advance();
        end
    endtask

    task automatic resetTest();
        #1;
        checkEq(32'(forwardAD), 32'(NOFORWARD), "forwardAD after reset");
        checkEq(32'(forwardBD), 32'(NOFORWARD), "forwardBD after reset");
        checkEq(32'(forwardAE), 32'(NOFORWARD), "forwardAE after reset");
        checkEq(32'(forwardBE), 32'(NOFORWARD), "forwardBE after reset");
        advance();
    endtask

    task automatic loadUseTest();
        drain();
        instrD = itype(`MIPS_OP_LW, 5'd1, 5'd8);
        advance();
        instrD = rtype(5'd8, 5'd2, 5'd9, `MIPS_FN_ADDU);
        {expStallFD, expFlushE} = 2'b11;
        checkShadowFwd();
        advance();
        // addu held in D while the load sits in M
        checkShadowFwd();
        advance();
        instrD = '0;
        checkShadowFwd();
        checkEq(32'(forwardAE), 32'(RESULTW), "forwardAE of addu behind load");
        advance();
    endtask

    task automatic forwardPriorityTest();
        integer r;
        drain();
        instrD = rtype(5'd1, 5'd2, 5'd5, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd3, 5'd4, 5'd5, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd5, 5'd0, 5'd6, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd0, `MIPS_FN_ADDU);
        checkShadowFwd();
        checkEq(32'(forwardAE), 32'(ALUOUTM), "forwardAE with writers in M and W");
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd7, `MIPS_FN_ADDU);
        advance();
        instrD = '0;
        checkShadowFwd();
        checkEq(32'(forwardAE), 32'(NOFORWARD), "forwardAE of register zero");
        advance();
        repeat (136) begin
            r = $random(seed);
            instrD = rtype({2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, `MIPS_FN_ADDU);
            checkShadowFwd();
            advance();
        end
    endtask

    task automatic branchTest();
        drain();
        instrD = rtype(5'd1, 5'd2, 5'd7, `MIPS_FN_ADDU);
        advance();
        instrD = itype(`MIPS_OP_BEQ, 5'd3, 5'd7);
        {expStallFD, expFlushE} = 2'b11;
        advance();
        #1;
        checkEq(32'(forwardBD), 32'(ALUOUTM), "forwardBD of held beq");
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd8, `MIPS_FN_MFHI);
        advance();
        // mfhi in E feeds the compare directly
        instrD = itype(`MIPS_OP_BEQ, 5'd8, 5'd0);
        checkShadowFwd();
        checkEq(32'(forwardAD), 32'(ALUSRCAE), "forwardAD from mfhi in E");
        advance();
        instrD = itype(`MIPS_OP_LW, 5'd1, 5'd9);
        advance();
        instrD = '0;
        advance();
        instrD = rtype(5'd9, 5'd0, 5'd0, `MIPS_FN_JR);
        {expStallFD, expFlushE} = 2'b11;
        advance();
        #1;
        checkEq(32'(forwardAD), 32'(RESULTW), "forwardAD of held jr");
        advance();
    endtask

    task automatic hiLoCp0Test();
        drain();
        instrD = rtype(5'd1, 5'd2, 5'd0, `MIPS_FN_MULT);
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd3, `MIPS_FN_MFHI);
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd4, `MIPS_FN_MFHI);
        #1;
        checkEq(32'(forwardAE), 32'(HIM), "forwardAE with mult in M");
        advance();
        instrD = rtype(5'd5, 5'd0, 5'd0, `MIPS_FN_MTLO);
        #1;
        checkEq(32'(forwardAE), 32'(HIW), "forwardAE with mult in W");
        advance();
        instrD = rtype(5'd0, 5'd0, 5'd6, `MIPS_FN_MFLO);
        advance();
        instrD = cop0(`MIPS_CP0_MT, 5'd5, 5'd12);
        #1;
        checkEq(32'(forwardAE), 32'(ALUOUTM), "forwardAE of mflo after mtlo");
        advance();
        instrD = cop0(`MIPS_CP0_MF, 5'd6, 5'd12);
        advance();
        instrD = cop0(`MIPS_CP0_MT, 5'd5, 5'd12);
        #1;
        checkEq(32'(forwardAE), 32'(ALUOUTM), "forwardAE of mfc0 at same address");
        advance();
        instrD = cop0(`MIPS_CP0_MF, 5'd7, 5'd13);
        advance();
        instrD = '0;
        #1;
        checkEq(32'(forwardAE), 32'(NOFORWARD), "forwardAE of mfc0 at other address");
        advance();
    endtask

    task automatic memWaitExceptionTest();
        drain();
        instrD = rtype(5'd1, 5'd2, 5'd10, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd3, 5'd4, 5'd11, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd11, 5'd10, 5'd12, `MIPS_FN_ADDU);
        advance();
        instrD = rtype(5'd12, 5'd0, 5'd13, `MIPS_FN_ADDU);
        dDataOk = 1'b0;
        {expStallFD, expStallEM, expFlushW} = 3'b111;
        checkShadowFwd();
        advance();
        // E and M held while W came up empty
        dDataOk = 1'b1;
        checkShadowFwd();
        checkEq(32'(forwardAE), 32'(ALUOUTM), "forwardAE after data wait");
        checkEq(32'(forwardBE), 32'(NOFORWARD), "forwardBE after data wait");
        advance();
        instrD = rtype(5'd1, 5'd2, 5'd14, `MIPS_FN_ADDU);
        iDataOk = 1'b0;
        {expStallFD, expFlushE} = 2'b11;
        checkShadowFwd();
        advance();
        iDataOk = 1'b1;
        checkShadowFwd();
        advance();
        instrD = itype(`MIPS_OP_LW, 5'd1, 5'd13);
        advance();
        instrD = rtype(5'd13, 5'd2, 5'd15, `MIPS_FN_ADDU);
        exceptionValid = 1'b1;
        {expFlushE, expFlushW, expFlushEx} = 3'b111;
        advance();
        exceptionValid = 1'b0;
        instrD = '0;
        isEret = 1'b1;
        {expFlushE, expFlushW, expFlushEx} = 3'b111;
        checkShadowFwd();
        checkEq(32'(forwardAE), 32'(NOFORWARD), "forwardAE after exception");
        advance();
        isEret = 1'b0;
        advance();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instrD = '0;
        iDataOk = 1'b1;
        dDataOk = 1'b1;
        exceptionValid = 1'b0;
        isEret = 1'b0;
        wE = '0;
        wM = '0;
        wW = '0;
        {expStallFD, expStallEM, expFlushE, expFlushW, expFlushEx} = '0;
        seed = 32'hed18;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        resetTest();
        loadUseTest();
        forwardPriorityTest();
        branchTest();
        hiLoCp0Test();
        memWaitExceptionTest();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- logic/hazardTop.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module hazardTop import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`MIPS_WORD_W-1:0] instrD,
    input  logic                    iDataOk,
    input  logic                    dDataOk,
    input  logic                    exceptionValid,
    input  logic                    isEret,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    stallE,
    output logic                    stallM,
    output logic                    flushD,
    output logic                    flushE,
    output logic                    flushM,
    output logic                    flushW,
    output logic                    flushEx,
    output forwardT                 forwardAD,
    output forwardT                 forwardBD,
    output forwardT                 forwardAE,
    output forwardT                 forwardBE
);
    // decode stage
    logic [`MIPS_REG_W-1:0] rsD, rtD, rdD, writeRegD;
    decodedOpT              opD;
    aluFuncT                aluFuncD;
    logic                   regWriteD, memToRegD, branchD, jrD;
    logic                   hiWriteD, loWriteD, cp0WriteD;
    logic                   hiToRegD, loToRegD, cp0ToRegD;

    // execute stage
    logic [`MIPS_REG_W-1:0] rsE, rtE, rdE, writeRegE;
    logic                   regWriteE, memToRegE;
    logic                   hiToRegE, loToRegE, cp0ToRegE;
    aluFuncT                aluFuncE;

    // memory stage
    logic [`MIPS_REG_W-1:0] rdM, writeRegM;
    logic                   regWriteM, memToRegM;
    logic                   hiWriteM, loWriteM, cp0WriteM;

    // write-back stage
    logic [`MIPS_REG_W-1:0] rdW, writeRegW;
    logic                   regWriteW;
    logic                   hiWriteW, loWriteW, cp0WriteW;

    instrDecode decodeInst (.*);

    stageTracker trackerInst (.*);

    hazard hazardInst (.*);

endmodule

//--- logic/hazard.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module hazard import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`MIPS_REG_W-1:0] rsD,
    input  logic [`MIPS_REG_W-1:0] rtD,
    input  decodedOpT              opD,
    input  logic                   branchD,
    input  logic                   jrD,
    input  logic [`MIPS_REG_W-1:0] rsE,
    input  logic [`MIPS_REG_W-1:0] rtE,
    input  logic [`MIPS_REG_W-1:0] rdE,
    input  logic [`MIPS_REG_W-1:0] writeRegE,
    input  logic                   regWriteE,
    input  logic                   memToRegE,
    input  logic                   hiToRegE,
    input  logic                   loToRegE,
    input  logic                   cp0ToRegE,
    input  aluFuncT                aluFuncE,
    input  logic [`MIPS_REG_W-1:0] rdM,
    input  logic [`MIPS_REG_W-1:0] writeRegM,
    input  logic                   regWriteM,
    input  logic                   memToRegM,
    input  logic                   hiWriteM,
    input  logic                   loWriteM,
    input  logic                   cp0WriteM,
    input  logic [`MIPS_REG_W-1:0] rdW,
    input  logic [`MIPS_REG_W-1:0] writeRegW,
    input  logic                   regWriteW,
    input  logic                   hiWriteW,
    input  logic                   loWriteW,
    input  logic                   cp0WriteW,
    input  logic                   iDataOk,
    input  logic                   dDataOk,
    input  logic                   exceptionValid,
    input  logic                   isEret,
    output logic                   stallF,
    output logic                   stallD,
    output logic                   stallE,
    output logic                   stallM,
    output logic                   flushD,
    output logic                   flushE,
    output logic                   flushM,
    output logic                   flushW,
    output logic                   flushEx,
    output forwardT                forwardAD,
    output forwardT                forwardBD,
    output forwardT                forwardAE,
    output forwardT                forwardBE
);
    logic lwStall;
    logic branchStall;
    logic isMultM;
    logic isMultW;
    logic specialM;
    logic specialW;

    // branch compare operands in D take E only when it passes source A
    function automatic forwardT decodeForward(input logic [`MIPS_REG_W-1:0] src);
        forwardT sel;
        if (src == '0) begin
            sel = NOFORWARD;
        end else if (regWriteE && writeRegE == src && aluFuncE == ALU_PASSA) begin
            sel = ALUSRCAE;
        end else if (regWriteM && writeRegM == src) begin
            sel = ALUOUTM;
        end else if (regWriteW && writeRegW == src) begin
            sel = RESULTW;
        end else begin
            sel = NOFORWARD;
        end
        return sel;
    endfunction

    always_comb begin
        forwardAD = decodeForward(rsD);
        forwardBD = decodeForward(rtD);
    end

    assign isMultM = hiWriteM & loWriteM;
    assign isMultW = hiWriteW & loWriteW;

    // hi/lo or cp0 (addressed by rd) written ahead of a reader in E
    assign specialM = (hiWriteM && hiToRegE) || (loWriteM && loToRegE) ||
                      (cp0WriteM && cp0ToRegE && rdM == rdE);
    assign specialW = (hiWriteW && hiToRegE) || (loWriteW && loToRegE) ||
                      (cp0WriteW && cp0ToRegE && rdW == rdE);

    always_comb begin
        if (isMultM && hiToRegE) begin
            forwardAE = HIM;
        end else if (isMultM && loToRegE) begin
            forwardAE = LOM;
        end else if (specialM) begin
            forwardAE = ALUOUTM;
        end else if (rsE != '0 && rsE == writeRegM && regWriteM) begin
            forwardAE = ALUOUTM;
        end else if (isMultW && hiToRegE) begin
            forwardAE = HIW;
        end else if (isMultW && loToRegE) begin
            forwardAE = LOW;
        end else if (specialW) begin
            forwardAE = RESULTW;
        end else if (rsE != '0 && rsE == writeRegW && regWriteW) begin
            forwardAE = RESULTW;
        end else begin
            forwardAE = NOFORWARD;
        end
    end

    always_comb begin
        if (rtE != '0 && rtE == writeRegM && regWriteM) begin
            forwardBE = ALUOUTM;
        end else if (rtE != '0 && rtE == writeRegW && regWriteW) begin
            forwardBE = RESULTW;
        end else begin
            forwardBE = NOFORWARD;
        end
    end

    assign lwStall = ((rsD == rtE) || (rtD == rtE)) && memToRegE;

    // mfhi/mflo/mfc0 in E are covered by the ALUSRCAE path
    assign branchStall = (branchD || jrD) && (aluFuncE != ALU_PASSA) &&
                         ((regWriteE && writeRegE == rsD) ||
                          (memToRegM && writeRegM == rsD) ||
                          (memToRegM && writeRegM == rtD) ||
                          ((opD == BEQ || opD == BNE) && regWriteE && writeRegE == rtD));

    assign flushEx = exceptionValid | isEret;

    assign stallF = ~iDataOk | ~dDataOk | ((lwStall | branchStall) & ~flushEx);
    assign stallD = ~dDataOk | ~iDataOk | ((lwStall | branchStall) & ~flushEx);
    assign stallE = ~dDataOk | (~iDataOk & flushEx);
    assign stallM = ~dDataOk | (~iDataOk & flushEx);

    assign flushD = flushEx;
    assign flushE = lwStall | branchStall | flushEx | ~iDataOk;
    assign flushM = flushEx;
    assign flushW = flushEx | ~dDataOk;

    // fetch logic outside relies on fetch and decode freezing together
    assert property (@(posedge clk) disable iff (!rstN) stallF == stallD);

    assert property (@(posedge clk) disable iff (!rstN) !dDataOk |-> stallM);

    assert property (@(posedge clk) disable iff (!rstN)
        (forwardAD == NOFORWARD || rsD != '0) &&
        (forwardBD == NOFORWARD || rtD != '0) &&
        (forwardBE == NOFORWARD || rtE != '0));

endmodule

//--- logic/stageTracker.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module stageTracker import mipsPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`MIPS_REG_W-1:0] rsD,
    input  logic [`MIPS_REG_W-1:0] rtD,
    input  logic [`MIPS_REG_W-1:0] rdD,
    input  logic [`MIPS_REG_W-1:0] writeRegD,
    input  decodedOpT              opD,
    input  aluFuncT                aluFuncD,
    input  logic                   regWriteD,
    input  logic                   memToRegD,
    input  logic                   hiWriteD,
    input  logic                   loWriteD,
    input  logic                   cp0WriteD,
    input  logic                   hiToRegD,
    input  logic                   loToRegD,
    input  logic                   cp0ToRegD,
    input  logic                   stallE,
    input  logic                   stallM,
    input  logic                   flushE,
    input  logic                   flushM,
    input  logic                   flushW,
    output logic [`MIPS_REG_W-1:0] rsE,
    output logic [`MIPS_REG_W-1:0] rtE,
    output logic [`MIPS_REG_W-1:0] rdE,
    output logic [`MIPS_REG_W-1:0] writeRegE,
    output logic                   regWriteE,
    output logic                   memToRegE,
    output logic                   hiToRegE,
    output logic                   loToRegE,
    output logic                   cp0ToRegE,
    output aluFuncT                aluFuncE,
    output logic [`MIPS_REG_W-1:0] rdM,
    output logic [`MIPS_REG_W-1:0] writeRegM,
    output logic                   regWriteM,
    output logic                   memToRegM,
    output logic                   hiWriteM,
    output logic                   loWriteM,
    output logic                   cp0WriteM,
    output logic [`MIPS_REG_W-1:0] rdW,
    output logic [`MIPS_REG_W-1:0] writeRegW,
    output logic                   regWriteW,
    output logic                   hiWriteW,
    output logic                   loWriteW,
    output logic                   cp0WriteW
);
    decodedOpT opE;
    decodedOpT opM;
    decodedOpT opW;
    logic      hiWriteE;
    logic      loWriteE;
    logic      cp0WriteE;

    // execute stage where a stall wins over a flush
    always_ff @(posedge clk) begin
        if (!rstN || (flushE && !stallE)) begin
            rsE       <= '0;
            rtE       <= '0;
            rdE       <= '0;
            writeRegE <= '0;
            opE       <= NOP;
            aluFuncE  <= ALU_ADD;
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            hiWriteE  <= 1'b0;
            loWriteE  <= 1'b0;
            cp0WriteE <= 1'b0;
            hiToRegE  <= 1'b0;
            loToRegE  <= 1'b0;
            cp0ToRegE <= 1'b0;
        end else if (!stallE) begin
            rsE       <= rsD;
            rtE       <= rtD;
            rdE       <= rdD;
            writeRegE <= writeRegD;
            opE       <= opD;
            aluFuncE  <= aluFuncD;
            regWriteE <= regWriteD;
            memToRegE <= memToRegD;
            hiWriteE  <= hiWriteD;
            loWriteE  <= loWriteD;
            cp0WriteE <= cp0WriteD;
            hiToRegE  <= hiToRegD;
            loToRegE  <= loToRegD;
            cp0ToRegE <= cp0ToRegD;
        end
    end

    // memory stage
    always_ff @(posedge clk) begin
        if (!rstN || (flushM && !stallM)) begin
            rdM       <= '0;
            writeRegM <= '0;
            opM       <= NOP;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            hiWriteM  <= 1'b0;
            loWriteM  <= 1'b0;
            cp0WriteM <= 1'b0;
        end else if (!stallM) begin
            rdM       <= rdE;
            writeRegM <= writeRegE;
            opM       <= opE;
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
            hiWriteM  <= hiWriteE;
            loWriteM  <= loWriteE;
            cp0WriteM <= cp0WriteE;
        end
    end

    // write-back never stalls
    always_ff @(posedge clk) begin
        if (!rstN || flushW) begin
            rdW       <= '0;
            writeRegW <= '0;
            opW       <= NOP;
            regWriteW <= 1'b0;
            hiWriteW  <= 1'b0;
            loWriteW  <= 1'b0;
            cp0WriteW <= 1'b0;
        end else begin
            rdW       <= rdM;
            writeRegW <= writeRegM;
            opW       <= opM;
            regWriteW <= regWriteM;
            hiWriteW  <= hiWriteM;
            loWriteW  <= loWriteM;
            cp0WriteW <= cp0WriteM;
        end
    end

    // a flushed stage comes up as a bubble one edge later
    assert property (@(posedge clk) disable iff (!rstN)
        (flushE && !stallE) |=> (!regWriteE && opE == NOP));
    assert property (@(posedge clk) disable iff (!rstN)
        (flushM && !stallM) |=> (!regWriteM && opM == NOP));
    assert property (@(posedge clk) disable iff (!rstN)
        flushW |=> (!regWriteW && opW == NOP));

endmodule

//--- logic/instrDecode.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module instrDecode import mipsPkg::*; (
    input  logic [`MIPS_WORD_W-1:0] instrD,
    output logic [`MIPS_REG_W-1:0]  rsD,
    output logic [`MIPS_REG_W-1:0]  rtD,
    output logic [`MIPS_REG_W-1:0]  rdD,
    output logic [`MIPS_REG_W-1:0]  writeRegD,
    output decodedOpT               opD,
    output aluFuncT                 aluFuncD,
    output logic                    regWriteD,
    output logic                    memToRegD,
    output logic                    branchD,
    output logic                    jrD,
    output logic                    hiWriteD,
    output logic                    loWriteD,
    output logic                    cp0WriteD,
    output logic                    hiToRegD,
    output logic                    loToRegD,
    output logic                    cp0ToRegD
);
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instrD[31:26];
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];
    assign rdD    = instrD[15:11];
    assign funct  = instrD[5:0];

    always_comb begin
        opD = NOP;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                case (funct)
                    `MIPS_FN_ADDU: opD = ADDU;
                    `MIPS_FN_SUBU: opD = SUBU;
                    `MIPS_FN_AND:  opD = AND;
                    `MIPS_FN_OR:   opD = OR;
                    `MIPS_FN_JR:   opD = JR;
                    `MIPS_FN_MULT: opD = MULT;
                    `MIPS_FN_MFHI: opD = MFHI;
                    `MIPS_FN_MFLO: opD = MFLO;
                    `MIPS_FN_MTHI: opD = MTHI;
                    `MIPS_FN_MTLO: opD = MTLO;
                    default:       opD = NOP;
                endcase
            end
            `MIPS_OP_LW:    opD = LW;
            `MIPS_OP_SW:    opD = SW;
            `MIPS_OP_BEQ:   opD = BEQ;
            `MIPS_OP_BNE:   opD = BNE;
            `MIPS_OP_ADDIU: opD = ADDIU;
            `MIPS_OP_COP0: begin
                // eret and friends are handled outside
                if (rsD == `MIPS_CP0_MF) begin
                    opD = MFC0;
                end else if (rsD == `MIPS_CP0_MT) begin
                    opD = MTC0;
                end
            end
            default: opD = NOP;
        endcase
    end

    always_comb begin
        case (opD)
            SUBU, BEQ, BNE:   aluFuncD = ALU_SUB;
            AND:              aluFuncD = ALU_AND;
            OR:               aluFuncD = ALU_OR;
            MFHI, MFLO, MFC0: aluFuncD = ALU_PASSA;
            default:          aluFuncD = ALU_ADD;
        endcase
    end

    assign regWriteD = opD inside {ADDU, SUBU, AND, OR, MFHI, MFLO, ADDIU, LW, MFC0};
    // i-type writers target rt
    assign writeRegD = (opD inside {LW, ADDIU, MFC0}) ? rtD : (regWriteD ? rdD : '0);
    assign memToRegD = (opD == LW);
    assign branchD   = opD inside {BEQ, BNE};
    assign jrD       = (opD == JR);
    assign hiWriteD  = opD inside {MULT, MTHI};
    assign loWriteD  = opD inside {MULT, MTLO};
    assign cp0WriteD = (opD == MTC0);
    assign hiToRegD  = (opD == MFHI);
    assign loToRegD  = (opD == MFLO);
    assign cp0ToRegD = (opD == MFC0);

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    // operand source for the D and E stage muxes
    typedef enum logic [2:0] {
        NOFORWARD = 3'd0,
        ALUSRCAE  = 3'd1,
        ALUOUTM   = 3'd2,
        RESULTW   = 3'd3,
        HIM       = 3'd4,
        LOM       = 3'd5,
        HIW       = 3'd6,
        LOW       = 3'd7
    } forwardT;

    // ALU_PASSA passes execute source A through (mfhi, mflo, mfc0)
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_PASSA = 3'd4
    } aluFuncT;

    // unknown words fall back to NOP
    typedef enum logic [4:0] {
        NOP   = 5'd0,
        ADDU  = 5'd1,
        SUBU  = 5'd2,
        AND   = 5'd3,
        OR    = 5'd4,
        ADDIU = 5'd5,
        LW    = 5'd6,
        SW    = 5'd7,
        BEQ   = 5'd8,
        BNE   = 5'd9,
        JR    = 5'd10,
        MULT  = 5'd11,
        MFHI  = 5'd12,
        MFLO  = 5'd13,
        MTHI  = 5'd14,
        MTLO  = 5'd15,
        MFC0  = 5'd16,
        MTC0  = 5'd17
    } decodedOpT;

endpackage

//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_WORD_W 32
`define MIPS_REG_W 5

// primary opcodes
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_LW 6'b100011
`define MIPS_OP_SW 6'b101011
`define MIPS_OP_BEQ 6'b000100
`define MIPS_OP_BNE 6'b000101
`define MIPS_OP_ADDIU 6'b001001
`define MIPS_OP_COP0 6'b010000

// funct field of SPECIAL
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR 6'b100101
`define MIPS_FN_JR 6'b001000
`define MIPS_FN_MULT 6'b011000
`define MIPS_FN_MFHI 6'b010000
`define MIPS_FN_MFLO 6'b010010
`define MIPS_FN_MTHI 6'b010001
`define MIPS_FN_MTLO 6'b010011

// rs field of COP0
`define MIPS_CP0_MF 5'b00000
`define MIPS_CP0_MT 5'b00100

`endif
